//--- hdl/video_core_pkg.sv
package video_core_pkg;

    // ********************
    // raster
    // ********************
    localparam int H_ACTIVE     = 32;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 6;
    localparam int H_BACK       = 6;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;

    localparam int V_ACTIVE     = 8;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    localparam int H_COUNT_W = $clog2(H_TOTAL);
    localparam int V_COUNT_W = $clog2(V_TOTAL);

    // ********************
    // memory and pixels
    // ********************
    localparam int COL_W       = 5;
    localparam int ROW_W       = 3;
    // bank, row, column
    localparam int VRAM_ADDR_W = 9;
    localparam int PIXEL_W     = 12;
    localparam int COLOR_W     = 4;

    // host bus
    localparam int                 WB_ADDR_W = 10;
    localparam int                 WB_DATA_W = 16;
    localparam logic [WB_ADDR_W-1:0] CTRL_ADDR = 10'h200;

    typedef enum logic [1:0] {FETCH_IDLE, FETCH_ISSUE, FETCH_DRAIN} prefetch_state_t;

    typedef enum logic [1:0] {ARB_NONE, ARB_READ, ARB_WRITE} arb_op_t;

endpackage

//--- hdl/video_timing_if.sv
interface video_timing_if
    import video_core_pkg::*;
();

    logic                 hsync_n;
    logic                 vsync_n;
    logic                 blank;
    logic [H_COUNT_W-1:0] h_pos;
    logic [ROW_W-1:0]     disp_row;
    // one pulse per line that precedes an active row
    logic                 fetch_start;
    logic [ROW_W-1:0]     fetch_row;
    logic                 frame_start;

    modport timer (
        output hsync_n, vsync_n, blank, h_pos, disp_row,
        output fetch_start, fetch_row, frame_start
    );

    modport fetcher (input fetch_start, fetch_row);

    modport pixel (input h_pos, disp_row, blank);

endinterface

//--- hdl/vram_if.sv
interface vram_read_if
    import video_core_pkg::*;
();

    logic [VRAM_ADDR_W-1:0] address;
    logic                   request;
    // returns two cycles after the request is taken
    logic [PIXEL_W-1:0]     data;
    logic                   data_valid;

    modport client (output address, request, input data, data_valid);

    modport arbiter (input address, request, output data, data_valid);

endinterface

interface vram_write_if
    import video_core_pkg::*;
();

    logic [VRAM_ADDR_W-1:0] address;
    logic [PIXEL_W-1:0]     data;
    logic                   request;
    logic                   done;

    modport client (output address, data, request, input done);

    modport arbiter (input address, data, request, output done);

endinterface

//--- hdl/video_timing.sv
module video_timing
    import video_core_pkg::*;
(
    input  logic          i_master_clk,
    input  logic          i_reset,
    video_timing_if.timer timing
);

    logic [H_COUNT_W-1:0] h_cnt;
    logic [V_COUNT_W-1:0] v_cnt;
    logic [H_COUNT_W-1:0] h_next;
    logic [V_COUNT_W-1:0] v_next;
    logic                 line_end;
    logic                 fetch_line;

    assign line_end = (h_cnt == H_COUNT_W'(H_TOTAL - 1));

    always_comb begin
        h_next = line_end ? '0 : h_cnt + 1'b1;
        v_next = v_cnt;
        if (line_end) begin
            v_next = (v_cnt == V_COUNT_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    // rows 1..7 on the active line before, row 0 on the last back porch line
    assign fetch_line = (v_next < V_ACTIVE - 1) || (v_next == V_TOTAL - 1);

    // registered from the next count, so everything lines up with h_pos
    always_ff @(posedge i_master_clk) begin
        if (i_reset) begin
            h_cnt              <= '0;
            v_cnt              <= '0;
            timing.hsync_n     <= 1'b1;
            timing.vsync_n     <= 1'b1;
            timing.blank       <= 1'b1;
            timing.fetch_start <= 1'b0;
            timing.fetch_row   <= '0;
            timing.frame_start <= 1'b0;
        end else begin
            h_cnt              <= h_next;
            v_cnt              <= v_next;
            timing.hsync_n     <= !((h_next >= H_SYNC_START) &&
                                    (h_next < H_SYNC_START + H_SYNC));
            timing.vsync_n     <= !((v_next >= V_SYNC_START) &&
                                    (v_next < V_SYNC_START + V_SYNC));
            timing.blank       <= (h_next >= H_ACTIVE) || (v_next >= V_ACTIVE);
            timing.fetch_start <= (h_next == '0) && fetch_line;
            timing.fetch_row   <= (v_next == V_COUNT_W'(V_TOTAL - 1)) ?
                                  '0 : ROW_W'(v_next + 1'b1);
            timing.frame_start <= (h_next == '0) && (v_next == V_SYNC_START);
        end
    end

    assign timing.h_pos    = h_cnt;
    assign timing.disp_row = v_cnt[ROW_W-1:0];

    // ********************
    // checks
    // ********************
    a_h_range: assert property (@(posedge i_master_clk) disable iff (i_reset)
        h_cnt < H_TOTAL);

    // a fetch always belongs to a line whose next row is on screen
    a_fetch_line: assert property (@(posedge i_master_clk) disable iff (i_reset)
        timing.fetch_start |-> ##H_TOTAL !timing.blank &&
            (timing.disp_row == $past(timing.fetch_row, H_TOTAL)));

endmodule

//--- hdl/prefetch_controller.sv
module prefetch_controller
    import video_core_pkg::*;
(
    input  logic                i_master_clk,
    input  logic                i_reset,
    input  logic                i_display_bank,
    video_timing_if.fetcher     timing,
    vram_read_if.client         vram,
    output logic                o_row_we,
    output logic                o_row_sel,
    output logic [COL_W-1:0]    o_row_col,
    output logic [PIXEL_W-1:0]  o_row_pixel
);

    prefetch_state_t  state;
    logic [ROW_W-1:0] row_q;
    logic             bank_q;
    logic [COL_W-1:0] issue_col;
    logic [COL_W-1:0] ret_col;

    always_ff @(posedge i_master_clk) begin
        if (i_reset) begin
            state     <= FETCH_IDLE;
            row_q     <= '0;
            bank_q    <= 1'b0;
            issue_col <= '0;
            ret_col   <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (timing.fetch_start) begin
                        row_q     <= timing.fetch_row;
                        bank_q    <= i_display_bank;
                        issue_col <= '0;
                        ret_col   <= '0;
                        state     <= FETCH_ISSUE;
                    end
                end
                FETCH_ISSUE: begin
                    issue_col <= issue_col + 1'b1;
                    if (issue_col == COL_W'(H_ACTIVE - 1)) begin
                        state <= FETCH_DRAIN;
                    end
                end
                FETCH_DRAIN: begin
                    // two reads still in flight
                    if (vram.data_valid && (ret_col == COL_W'(H_ACTIVE - 1))) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
            if (vram.data_valid) begin
                ret_col <= ret_col + 1'b1;
            end
        end
    end

    assign vram.request = (state == FETCH_ISSUE);
    assign vram.address = {bank_q, row_q, issue_col};

    // returns go straight into the row memory of the fetched row
    assign o_row_we    = vram.data_valid;
    assign o_row_sel   = row_q[0];
    assign o_row_col   = ret_col;
    assign o_row_pixel = vram.data;

    // a row fetch must finish within its line
    a_fetch_idle: assert property (@(posedge i_master_clk) disable iff (i_reset)
        timing.fetch_start |-> state == FETCH_IDLE);

endmodule

//--- hdl/row_buffer.sv
module row_buffer
    import video_core_pkg::*;
(
    input  logic               i_master_clk,
    input  logic               i_reset,
    input  logic               i_row_we,
    input  logic               i_row_sel,
    input  logic [COL_W-1:0]   i_row_col,
    input  logic [PIXEL_W-1:0] i_row_pixel,
    video_timing_if.pixel      timing,
    output logic [COLOR_W-1:0] o_red,
    output logic [COLOR_W-1:0] o_green,
    output logic [COLOR_W-1:0] o_blue
);

    // even and odd rows
    logic [PIXEL_W-1:0] row_mem [0:1][0:H_ACTIVE-1];
    logic [PIXEL_W-1:0] rd_pixel;

    always_ff @(posedge i_master_clk) begin
        if (i_row_we) begin
            row_mem[i_row_sel][i_row_col] <= i_row_pixel;
        end
    end

    assign rd_pixel = row_mem[timing.disp_row[0]][timing.h_pos[COL_W-1:0]];

    // ********************
    // pixel out
    // ********************
    always_ff @(posedge i_master_clk) begin
        if (i_reset || timing.blank) begin
            o_red   <= '0;
            o_green <= '0;
            o_blue  <= '0;
        end else begin
            o_red   <= rd_pixel[3*COLOR_W-1:2*COLOR_W];
            o_green <= rd_pixel[2*COLOR_W-1:COLOR_W];
            o_blue  <= rd_pixel[COLOR_W-1:0];
        end
    end

endmodule

//--- hdl/vram_arbiter.sv
module vram_arbiter
    import video_core_pkg::*;
(
    input  logic                   i_master_clk,
    input  logic                   i_reset,
    vram_read_if.arbiter           rd,
    vram_write_if.arbiter          wr,
    output logic [VRAM_ADDR_W-1:0] o_sram_address,
    output logic [PIXEL_W-1:0]     o_sram_data_out,
    output logic                   o_sram_data_dir_out,
    output logic                   o_sram_cs_n,
    output logic                   o_sram_oe_n,
    output logic                   o_sram_we_n,
    input  logic [PIXEL_W-1:0]     i_sram_data_in
);

    arb_op_t            op;
    // operation currently on the pins
    arb_op_t            op_q;
    logic [1:0]         rd_pipe;
    logic [PIXEL_W-1:0] rd_data;

    // reads first, writes only in free slots
    always_comb begin
        if (rd.request) begin
            op = ARB_READ;
        end else if (wr.request && (op_q != ARB_WRITE)) begin
            op = ARB_WRITE;
        end else begin
            op = ARB_NONE;
        end
    end

    assign wr.done       = (op_q == ARB_WRITE);
    assign rd.data       = rd_data;
    assign rd.data_valid = rd_pipe[1];

    // ********************
    // sram pins
    // ********************
    always_ff @(posedge i_master_clk) begin
        if (i_reset) begin
            op_q                <= ARB_NONE;
            rd_pipe             <= '0;
            o_sram_cs_n         <= 1'b1;
            o_sram_oe_n         <= 1'b1;
            o_sram_we_n         <= 1'b1;
            o_sram_data_dir_out <= 1'b0;
        end else begin
            op_q                <= op;
            rd_pipe             <= {rd_pipe[0], op == ARB_READ};
            o_sram_cs_n         <= (op == ARB_NONE);
            o_sram_oe_n         <= (op != ARB_READ);
            o_sram_we_n         <= (op != ARB_WRITE);
            o_sram_data_dir_out <= (op == ARB_WRITE);
        end
    end

    always_ff @(posedge i_master_clk) begin
        o_sram_address  <= (op == ARB_WRITE) ? wr.address : rd.address;
        o_sram_data_out <= wr.data;
        // sram answers during the cycle its address is on the pins
        if (rd_pipe[0]) begin
            rd_data <= i_sram_data_in;
        end
    end

    a_we_dir: assert property (@(posedge i_master_clk) disable iff (i_reset)
        !o_sram_we_n |-> o_sram_data_dir_out);

    a_we_oe: assert property (@(posedge i_master_clk) disable iff (i_reset)
        !(!o_sram_we_n && !o_sram_oe_n));

endmodule

//--- hdl/wb_host_port.sv
module wb_host_port
    import video_core_pkg::*;
(
    input  logic                 i_master_clk,
    input  logic                 i_reset,
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  logic [WB_ADDR_W-1:0] i_wb_adr,
    input  logic [WB_DATA_W-1:0] i_wb_dat,
    output logic [WB_DATA_W-1:0] o_wb_dat,
    output logic                 o_wb_ack,
    input  logic                 i_frame_start,
    vram_write_if.client         vram,
    output logic                 o_display_bank
);

    logic ctrl_hit;
    logic pixel_hit;
    logic bus_req;
    logic wr_pending;
    logic pending_bank;

    assign ctrl_hit  = (i_wb_adr == CTRL_ADDR);
    assign pixel_hit = !i_wb_adr[WB_ADDR_W-1];
    // new transfer, not one already being served
    assign bus_req   = i_wb_cyc && i_wb_stb && !o_wb_ack && !wr_pending;

    assign vram.request = wr_pending;

    always_ff @(posedge i_master_clk) begin
        if (i_reset) begin
            wr_pending     <= 1'b0;
            o_wb_ack       <= 1'b0;
            pending_bank   <= 1'b0;
            o_display_bank <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;
            if (bus_req) begin
                if (i_wb_we && pixel_hit) begin
                    wr_pending <= 1'b1;
                end else begin
                    o_wb_ack <= 1'b1;
                    if (i_wb_we && ctrl_hit) begin
                        pending_bank <= i_wb_dat[0];
                    end
                end
            end
            if (wr_pending && vram.done) begin
                wr_pending <= 1'b0;
                o_wb_ack   <= 1'b1;
            end
            // bank swap only at the start of vsync
            if (i_frame_start) begin
                o_display_bank <= pending_bank;
            end
        end
    end

    always_ff @(posedge i_master_clk) begin
        if (bus_req) begin
            vram.address <= i_wb_adr[VRAM_ADDR_W-1:0];
            vram.data    <= i_wb_dat[PIXEL_W-1:0];
            o_wb_dat     <= ctrl_hit ? {{(WB_DATA_W-1){1'b0}}, pending_bank} : '0;
        end
    end

    a_ack_in_cycle: assert property (@(posedge i_master_clk) disable iff (i_reset)
        $rose(o_wb_ack) |-> i_wb_cyc && i_wb_stb);

endmodule

//--- hdl/video_core.sv
module video_core
    import video_core_pkg::*;
(
    input  logic                   i_master_clk,
    input  logic                   i_reset,

    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  logic [WB_ADDR_W-1:0]   i_wb_adr,
    input  logic [WB_DATA_W-1:0]   i_wb_dat,
    output logic [WB_DATA_W-1:0]   o_wb_dat,
    output logic                   o_wb_ack,

    output logic                   o_video_hsync,
    output logic                   o_video_vsync,
    output logic [COLOR_W-1:0]     o_video_red,
    output logic [COLOR_W-1:0]     o_video_green,
    output logic [COLOR_W-1:0]     o_video_blue,

    output logic [VRAM_ADDR_W-1:0] o_sram_address,
    output logic [PIXEL_W-1:0]     o_sram_data_out,
    output logic                   o_sram_data_dir_out,
    input  logic [PIXEL_W-1:0]     i_sram_data_in,
    output logic                   o_sram_cs_n,
    output logic                   o_sram_oe_n,
    output logic                   o_sram_we_n
);

    video_timing_if timing ();
    vram_read_if    vram_rd ();
    vram_write_if   vram_wr ();

    logic               display_bank;
    logic               row_we;
    logic               row_sel;
    logic [COL_W-1:0]   row_col;
    logic [PIXEL_W-1:0] row_pixel;

    // ********************
    // display path
    // ********************
    video_timing timing_i (
        .i_master_clk (i_master_clk),
        .i_reset      (i_reset),
        .timing       (timing.timer)
    );

    prefetch_controller prefetch_i (
        .i_master_clk   (i_master_clk),
        .i_reset        (i_reset),
        .i_display_bank (display_bank),
        .timing         (timing.fetcher),
        .vram           (vram_rd.client),
        .o_row_we       (row_we),
        .o_row_sel      (row_sel),
        .o_row_col      (row_col),
        .o_row_pixel    (row_pixel)
    );

    row_buffer row_buffer_i (
        .i_master_clk (i_master_clk),
        .i_reset      (i_reset),
        .i_row_we     (row_we),
        .i_row_sel    (row_sel),
        .i_row_col    (row_col),
        .i_row_pixel  (row_pixel),
        .timing       (timing.pixel),
        .o_red        (o_video_red),
        .o_green      (o_video_green),
        .o_blue       (o_video_blue)
    );

    // sync gets the same one cycle delay as the rgb register
    always_ff @(posedge i_master_clk) begin
        if (i_reset) begin
            o_video_hsync <= 1'b1;
            o_video_vsync <= 1'b1;
        end else begin
            o_video_hsync <= timing.hsync_n;
            o_video_vsync <= timing.vsync_n;
        end
    end

    // ********************
    // host and sram
    // ********************
    wb_host_port host_i (
        .i_master_clk   (i_master_clk),
        .i_reset        (i_reset),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .i_frame_start  (timing.frame_start),
        .vram           (vram_wr.client),
        .o_display_bank (display_bank)
    );

    vram_arbiter arbiter_i (
        .i_master_clk        (i_master_clk),
        .i_reset             (i_reset),
        .rd                  (vram_rd.arbiter),
        .wr                  (vram_wr.arbiter),
        .o_sram_address      (o_sram_address),
        .o_sram_data_out     (o_sram_data_out),
        .o_sram_data_dir_out (o_sram_data_dir_out),
        .o_sram_cs_n         (o_sram_cs_n),
        .o_sram_oe_n         (o_sram_oe_n),
        .o_sram_we_n         (o_sram_we_n),
        .i_sram_data_in      (i_sram_data_in)
    );

endmodule

//--- verification/sram_model.sv
module sram_model
    import video_core_pkg::*;
(
    input  logic [VRAM_ADDR_W-1:0] i_address,
    input  logic [PIXEL_W-1:0]     i_data,
    output logic [PIXEL_W-1:0]     o_data,
    input  logic                   i_cs_n,
    input  logic                   i_oe_n,
    input  logic                   i_we_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // pins settle this long after the clock edge that drives them
    localparam int SETTLE = 2;

    logic [PIXEL_W-1:0] mem [0:(1 << VRAM_ADDR_W)-1];

    // power-up contents differ from every pixel the host writes
    initial begin
        for (int i = 0; i < (1 << VRAM_ADDR_W); i++) begin
            mem[i] = {3'b101, VRAM_ADDR_W'(i)};
        end
    end

    // combinational read port
    assign o_data = (!i_cs_n && !i_oe_n) ? mem[i_address] : 'x;

    // one write per strobe, taken once address and data are stable
    always @(negedge i_we_n) begin
        #(SETTLE);
        if (!i_we_n && !i_cs_n) begin
            mem[i_address] = i_data;
        end
    end

endmodule

//--- verification/video_core_tb.sv
module video_core_tb
    import video_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int     CLK_PERIOD      = 8;
    localparam longint WATCHDOG_CYCLES = 2 * 512 * 40 + 8 * V_TOTAL * H_TOTAL;

    logic                   i_master_clk;
    logic                   i_reset;
    logic                   i_wb_cyc;
    logic                   i_wb_stb;
    logic                   i_wb_we;
    logic [WB_ADDR_W-1:0]   i_wb_adr;
    logic [WB_DATA_W-1:0]   i_wb_dat;
    logic [WB_DATA_W-1:0]   o_wb_dat;
    logic                   o_wb_ack;
    logic                   o_video_hsync;
    logic                   o_video_vsync;
    logic [COLOR_W-1:0]     o_video_red;
    logic [COLOR_W-1:0]     o_video_green;
    logic [COLOR_W-1:0]     o_video_blue;
    logic [VRAM_ADDR_W-1:0] o_sram_address;
    logic [PIXEL_W-1:0]     o_sram_data_out;
    logic                   o_sram_data_dir_out;
    logic [PIXEL_W-1:0]     i_sram_data_in;
    logic                   o_sram_cs_n;
    logic                   o_sram_oe_n;
    logic                   o_sram_we_n;

    // raster position of the outputs seen at the next clock edge
    int                 col;
    int                 row;
    logic               h_locked;
    logic               v_locked;
    logic               prev_hsync;
    logic               prev_vsync;
    logic               check_en;
    logic               exp_bank;
    logic               exp_ctrl;
    integer             seed;
    logic               exp_hsync;
    logic               exp_vsync;
    logic               active_area;
    logic [PIXEL_W-1:0] exp_pixel;
    logic [PIXEL_W-1:0] out_pixel;

    video_core dut_i (.*);

    sram_model sram_i (
        .i_address (o_sram_address),
        .i_data    (o_sram_data_out),
        .o_data    (i_sram_data_in),
        .i_cs_n    (o_sram_cs_n),
        .i_oe_n    (o_sram_oe_n),
        .i_we_n    (o_sram_we_n)
    );

    always #(CLK_PERIOD / 2) i_master_clk = ~i_master_clk;

    // red is the row, green the column, blue tells the bank
    function automatic logic [PIXEL_W-1:0] pixel_value(input logic bank, input int r,
                                                       input int c);
        logic [COLOR_W-1:0] blue;
        blue = bank ? 4'h5 : 4'hA;
        return {COLOR_W'(r), COLOR_W'(c % 16), blue};
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        stop_run();
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // ********************
    // raster tracking
    // ********************
    always_ff @(posedge i_master_clk) begin
        prev_hsync <= o_video_hsync;
        prev_vsync <= o_video_vsync;
        if (i_reset) begin
            h_locked <= 1'b0;
            v_locked <= 1'b0;
            col      <= 0;
            row      <= 0;
        end else begin
            if (h_locked) begin
                col <= (col == H_TOTAL - 1) ? 0 : col + 1;
            end else if (prev_hsync && !o_video_hsync) begin
                h_locked <= 1'b1;
                col      <= H_SYNC_START + 1;
            end
            if (v_locked) begin
                if (col == H_TOTAL - 1) begin
                    row <= (row == V_TOTAL - 1) ? 0 : row + 1;
                end
            end else if (h_locked && prev_vsync && !o_video_vsync) begin
                // vsync falls on column 0 of the first sync line
                v_locked <= 1'b1;
                row      <= V_SYNC_START;
            end
        end
    end

    assign exp_hsync   = !((col >= H_SYNC_START) && (col < H_SYNC_START + H_SYNC));
    assign exp_vsync   = !((row >= V_SYNC_START) && (row < V_SYNC_START + V_SYNC));
    assign active_area = (col < H_ACTIVE) && (row < V_ACTIVE);
    assign exp_pixel   = pixel_value(exp_bank, row, col);
    assign out_pixel   = {o_video_red, o_video_green, o_video_blue};

    // ********************
    // checks
    // ********************
    a_hsync: assert property (@(posedge i_master_clk) disable iff (i_reset)
        h_locked |-> o_video_hsync == exp_hsync)
        else report_mismatch("o_video_hsync", $sampled(exp_hsync), $sampled(o_video_hsync));

    a_vsync: assert property (@(posedge i_master_clk) disable iff (i_reset)
        v_locked |-> o_video_vsync == exp_vsync)
        else report_mismatch("o_video_vsync", $sampled(exp_vsync), $sampled(o_video_vsync));

    a_blank: assert property (@(posedge i_master_clk) disable iff (i_reset)
        (v_locked && !active_area) |-> out_pixel == '0)
        else report_mismatch("rgb", 16'h0, $sampled(out_pixel));

    a_pixel: assert property (@(posedge i_master_clk) disable iff (i_reset)
        (check_en && v_locked && active_area) |-> out_pixel == exp_pixel)
        else report_mismatch("rgb", $sampled(exp_pixel), $sampled(out_pixel));

    a_ctrl_read: assert property (@(posedge i_master_clk) disable iff (i_reset)
        (o_wb_ack && !i_wb_we && (i_wb_adr == CTRL_ADDR)) |-> o_wb_dat == WB_DATA_W'(exp_ctrl))
        else report_mismatch("o_wb_dat", WB_DATA_W'($sampled(exp_ctrl)), $sampled(o_wb_dat));

    a_ack_cycle: assert property (@(posedge i_master_clk) disable iff (i_reset)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else report_error("wishbone ack seen outside an active bus cycle");

    a_ack_pulse: assert property (@(posedge i_master_clk) disable iff (i_reset)
        o_wb_ack |=> !o_wb_ack)
        else report_error("wishbone ack held for more than one cycle");

    a_sram_dir: assert property (@(posedge i_master_clk) disable iff (i_reset)
        !o_sram_we_n |-> o_sram_data_dir_out)
        else report_error("sram write strobe low while the data bus is not driven");

    a_sram_we_oe: assert property (@(posedge i_master_clk) disable iff (i_reset)
        !(!o_sram_we_n && !o_sram_oe_n))
        else report_error("sram write and output enable low in the same cycle");

    // ********************
    // bus and raster tasks
    // ********************
    task automatic next_cycle();
        @(posedge i_master_clk);
        #1;
    endtask

    // master holds the request until ack
    task automatic bus_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] dat);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        do begin
            @(posedge i_master_clk);
        end while (!o_wb_ack);
        #1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic write_ctrl(input logic bank);
        bus_cycle(1'b1, CTRL_ADDR, WB_DATA_W'(bank));
        exp_ctrl = bank;
    endtask

    task automatic fill_banks();
        int gap;
        for (int b = 0; b < 2; b++) begin
            for (int r = 0; r < V_ACTIVE; r++) begin
                for (int c = 0; c < H_ACTIVE; c++) begin
                    gap = $unsigned($random(seed)) % 6;
                    repeat (gap) begin
                        next_cycle();
                    end
                    bus_cycle(1'b1, WB_ADDR_W'({1'(b), ROW_W'(r), COL_W'(c)}),
                              WB_DATA_W'(pixel_value(b, r, c)));
                end
            end
        end
    endtask

    // returns just before row 0, column 0 reaches the outputs
    task automatic wait_frame_start();
        do begin
            next_cycle();
        end while (!(v_locked && (row == 0) && (col == 0)));
    endtask

    task automatic wait_row(input int r);
        do begin
            next_cycle();
        end while (!(v_locked && (row == r) && (col == 0)));
    endtask

    // ********************
    // stimulus
    // ********************
    initial begin
        i_master_clk = 1'b0;
        i_reset      = 1'b1;
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_wb_we      = 1'b0;
        i_wb_adr     = '0;
        i_wb_dat     = '0;
        check_en     = 1'b0;
        exp_bank     = 1'b0;
        exp_ctrl     = 1'b0;
        seed         = 71;
        repeat (10) @(posedge i_master_clk);
        #1;
        i_reset = 1'b0;

        bus_cycle(1'b0, CTRL_ADDR, '0);
        fill_banks();
        write_ctrl(1'b0);
        // the first frame may hold rows fetched before the last writes
        wait_frame_start();
        wait_frame_start();
        check_en = 1'b1;
        wait_frame_start();

        // bank switch in mid-frame, visible only from the next frame
        wait_row(V_ACTIVE / 2);
        write_ctrl(1'b1);
        wait_frame_start();
        exp_bank = 1'b1;
        wait_frame_start();
        bus_cycle(1'b0, CTRL_ADDR, '0);

        $display("Test passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run did not finish in time");
        stop_run();
    end

endmodule

//--- video_core.f
hdl/video_core_pkg.sv
hdl/video_timing_if.sv
hdl/vram_if.sv
hdl/video_timing.sv
hdl/prefetch_controller.sv
hdl/row_buffer.sv
hdl/vram_arbiter.sv
hdl/wb_host_port.sv
hdl/video_core.sv
verification/sram_model.sv
verification/video_core_tb.sv

//--- Bender.yml
package:
  name: video_core

sources:
  - files:
      - hdl/video_core_pkg.sv
      - hdl/video_timing_if.sv
      - hdl/vram_if.sv
      - hdl/video_timing.sv
      - hdl/prefetch_controller.sv
      - hdl/row_buffer.sv
      - hdl/vram_arbiter.sv
      - hdl/wb_host_port.sv
      - hdl/video_core.sv
  - target: simulation
    files:
      - verification/sram_model.sv
      - verification/video_core_tb.sv
